// ==== tb.f ====
+incdir+rtl
rtl/decodePkg.sv
rtl/mainControl.sv
rtl/registerFile.sv
rtl/branchResolve.sv
rtl/hazardUnit.sv
rtl/instructionDecode.sv
tb/decodeTb.sv

// ==== Makefile ====
TOP = decodeTb

.PHONY: all lint clean

all:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "test passed"

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== tb/decodeTb.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module decodeTb;

  logic                            Clock = 1'b0;
  logic                            reset;
  decodePkg::instrWord             instruction;
  logic [`DECODE_XLEN-1:0]         pcPlusFour;
  logic [`DECODE_REG_AW-1:0]       writeAddr;
  logic [`DECODE_XLEN-1:0]         writeData;
  logic                            regWrite;
  decodePkg::pipeHazardInfo        hazardInfo;
  decodePkg::ctrlSignals           ctrl;
  logic [`DECODE_XLEN-1:0]         readData1;
  logic [`DECODE_XLEN-1:0]         readData2;
  logic [`DECODE_XLEN-1:0]         imm32;
  logic                            pcSel;
  logic [`DECODE_XLEN-1:0]         branchPc;
  decodePkg::stallSignals          stall;

  int                              errorCount = 0;
  logic [31:0]                     lfsrState  = 32'hde2f0e82;
  // Expected register contents
  logic [`DECODE_XLEN-1:0]         regModel [32];

  // 40 ns period
  always #20 Clock = ~Clock;

  instructionDecode instructionDecode_i (
    .Clock       (Clock),
    .reset       (reset),
    .instruction (instruction),
    .pcPlusFour  (pcPlusFour),
    .writeAddr   (writeAddr),
    .writeData   (writeData),
    .regWrite    (regWrite),
    .hazardInfo  (hazardInfo),
    .ctrl        (ctrl),
    .readData1   (readData1),
    .readData2   (readData2),
    .imm32       (imm32),
    .pcSel       (pcSel),
    .branchPc    (branchPc),
    .stall       (stall)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR x^32+x^22+x^2+x+1 stepped once per bit
  function automatic logic [31:0] nextBits(input int count);
    logic [31:0] result;
    logic        feedback;
    result = '0;
    for (int i = 0; i < count; i++) begin
      feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], feedback};
      result    = {result[30:0], feedback};
    end
    return result;
  endfunction

  function automatic decodePkg::instrWord rTypeWord(input logic [4:0] rs, input logic [4:0] rt,
                                                    input logic [4:0] rd, input logic [5:0] fn);
    decodePkg::instrWord w;
    w.rFormat.opcode = `OPC_RTYPE;
    w.rFormat.rs     = rs;
    w.rFormat.rt     = rt;
    w.rFormat.rd     = rd;
    w.rFormat.shamt  = 5'd0;
    w.rFormat.funct  = fn;
    return w;
  endfunction

  function automatic decodePkg::instrWord iTypeWord(input logic [5:0] opc, input logic [4:0] rs,
                                                    input logic [4:0] rt, input logic [15:0] imm);
    decodePkg::instrWord w;
    w.iFormat.opcode = opc;
    w.iFormat.rs     = rs;
    w.iFormat.rt     = rt;
    w.iFormat.imm    = imm;
    return w;
  endfunction

  function automatic decodePkg::pipeHazardInfo hazardFields(
      input logic [5:0] exOpc, input logic [4:0] exRt, input logic [4:0] exRd,
      input logic [5:0] memOpc, input logic [4:0] memDest);
    decodePkg::pipeHazardInfo h;
    h.exOpcode  = exOpc;
    h.exRt      = exRt;
    h.exRd      = exRd;
    h.memOpcode = memOpc;
    h.memDest   = memDest;
    return h;
  endfunction

  function automatic logic [31:0] signExtend(input logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

  // Access size code with byte 0, half 1 and word 2
  function automatic logic [1:0] sizeCode(input logic [5:0] opc);
    if (opc == `OPC_LB || opc == `OPC_SB)
      return 2'd0;
    else if (opc == `OPC_LH || opc == `OPC_SH)
      return 2'd1;
    return 2'd2;
  endfunction

  // Control word from the decode rule table
  function automatic decodePkg::ctrlSignals expectedCtrl(input logic [5:0] opc,
                                                         input logic [5:0] fn);
    decodePkg::ctrlSignals c;
    logic                  isAlu;
    logic                  isAddi;
    logic                  isLoad;
    logic                  isStore;
    c       = '0;
    isAlu   = (opc == `OPC_RTYPE) && (fn == `FN_ADD || fn == `FN_SUB || fn == `FN_AND ||
                                      fn == `FN_OR || fn == `FN_SLT);
    isAddi  = (opc == `OPC_ADDI);
    isLoad  = (opc == `OPC_LB) || (opc == `OPC_LH) || (opc == `OPC_LW);
    isStore = (opc == `OPC_SB) || (opc == `OPC_SH) || (opc == `OPC_SW);
    c.regDst   = isAlu;
    c.aluSrc1  = (isAddi || isLoad || isStore) ? 2'd1 : 2'd0;
    c.rEnable  = isLoad;
    c.memToReg = isLoad;
    c.wEnable  = isStore;
    c.regWrite = isAlu || isAddi || isLoad;
    if (isLoad)
      c.rWidth = sizeCode(opc);
    if (isStore)
      c.wWidth = sizeCode(opc);
    return c;
  endfunction

  // Drive on the rising edge and sample at the falling edge
  task automatic applyInputs(input decodePkg::instrWord instr, input logic [31:0] pc,
                             input decodePkg::pipeHazardInfo hz);
    @(posedge Clock);
    instruction <= instr;
    pcPlusFour  <= pc;
    hazardInfo  <= hz;
    @(negedge Clock);
  endtask

  // Writeback stand-in for one write cycle
  task automatic writeRegister(input logic [4:0] addr, input logic [31:0] data);
    @(posedge Clock);
    writeAddr <= addr;
    writeData <= data;
    regWrite  <= 1'b1;
    @(posedge Clock);
    regWrite  <= 1'b0;
    if (addr != 5'd0)
      regModel[addr] = data;
  endtask

  task automatic waitResetRelease(output logic released);
    int cycles;
    cycles = 0;
    while (reset && cycles < 20) begin
      @(negedge Clock);
      cycles++;
    end
    released = !reset;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic ctrlCompare(input string testName, input decodePkg::ctrlSignals expected,
                             input decodePkg::ctrlSignals actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %h actual %h", testName, expected, actual);
      errorCount++;
    end
  endtask

  task automatic stallCompare(input string testName, input decodePkg::stallSignals expected,
                              input decodePkg::stallSignals actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %b actual %b", testName, expected, actual);
      errorCount++;
    end
  endtask

  task automatic wordCompare(input string testName, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %h actual %h", testName, expected, actual);
      errorCount++;
    end
  endtask

  task automatic bitCompare(input string testName, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %b actual %b", testName, expected, actual);
      errorCount++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic registerFileTest;
    logic [31:0] bits;
    logic [4:0]  addr;
    logic [31:0] data;
    for (int r = 0; r < 32; r++)
      regModel[r] = '0;
    // Random data into random registers 1..31
    repeat (16) begin
      bits = nextBits(5);
      addr = (bits[4:0] == 5'd0) ? 5'd1 : bits[4:0];
      writeRegister(addr, nextBits(32));
    end
    for (int r = 1; r < 32; r++) begin
      applyInputs(rTypeWord(5'(r), 5'(32 - r), 5'd1, `FN_OR), 32'd0, '0);
      wordCompare($sformatf("regfile readback rs r%0d", r), regModel[r], readData1);
      wordCompare($sformatf("regfile readback rt r%0d", 32 - r), regModel[32 - r], readData2);
    end
    // Reset again while the registers hold live data
    @(posedge Clock);
    reset <= 1'b1;
    repeat (4) @(posedge Clock);
    reset <= 1'b0;
    // Cleared by reset
    for (int r = 0; r < 32; r++) begin
      regModel[r] = '0;
      applyInputs(rTypeWord(5'(r), 5'(r), 5'd0, `FN_ADD), 32'd0, '0);
      wordCompare($sformatf("regfile reset rs r%0d", r), 32'd0, readData1);
      wordCompare($sformatf("regfile reset rt r%0d", r), 32'd0, readData2);
    end
    // r0 ignores writes
    @(posedge Clock);
    writeAddr   <= 5'd0;
    writeData   <= nextBits(32);
    regWrite    <= 1'b1;
    instruction <= rTypeWord(5'd0, 5'd0, 5'd2, `FN_ADD);
    @(negedge Clock);
    wordCompare("regfile r0 write rs", 32'd0, readData1);
    wordCompare("regfile r0 write rt", 32'd0, readData2);
    @(posedge Clock);
    regWrite <= 1'b0;
    @(negedge Clock);
    wordCompare("regfile r0 after write", 32'd0, readData1);
    // Same-cycle bypass on r7
    data = ~regModel[7];
    @(posedge Clock);
    writeAddr   <= 5'd7;
    writeData   <= data;
    regWrite    <= 1'b1;
    instruction <= rTypeWord(5'd7, 5'd7, 5'd3, `FN_SUB);
    @(negedge Clock);
    wordCompare("regfile bypass rs", data, readData1);
    wordCompare("regfile bypass rt", data, readData2);
    @(posedge Clock);
    regWrite    <= 1'b0;
    regModel[7]  = data;
    @(negedge Clock);
    wordCompare("regfile bypass stored", data, readData1);
  endtask

  // Every opcode and then every funct under R-type
  task automatic controlDecodeTest;
    logic [31:0] bits;
    for (int op = 0; op < 64; op++) begin
      bits = nextBits(26);
      applyInputs(iTypeWord(6'(op), bits[25:21], bits[20:16], bits[15:0]), 32'd0, '0);
      ctrlCompare($sformatf("control opcode %h", op), expectedCtrl(6'(op), bits[5:0]), ctrl);
    end
    for (int fn = 0; fn < 64; fn++) begin
      bits = nextBits(15);
      applyInputs(rTypeWord(bits[14:10], bits[9:5], bits[4:0], 6'(fn)), 32'd0, '0);
      ctrlCompare($sformatf("control funct %h", fn), expectedCtrl(`OPC_RTYPE, 6'(fn)), ctrl);
    end
  endtask

  task automatic immBranchTest;
    logic [31:0] bits;
    logic [31:0] pc;
    logic [31:0] data;
    logic [5:0]  opc;
    logic [4:0]  rt;
    logic        equal;
    logic        taken;
    repeat (16) begin
      bits = nextBits(16);
      pc   = nextBits(32);
      applyInputs(iTypeWord(`OPC_ADDI, 5'd1, 5'd2, bits[15:0]), pc, '0);
      wordCompare("sign extension", signExtend(bits[15:0]), imm32);
      wordCompare("branch candidate", pc + (signExtend(bits[15:0]) << 2), branchPc);
      bitCompare("addi pcSel", 1'b0, pcSel);
    end
    // Equal pair r5/r6 and unequal pair r5/r7
    data = nextBits(32);
    writeRegister(5'd5, data);
    writeRegister(5'd6, data);
    writeRegister(5'd7, ~data);
    for (int k = 0; k < 4; k++) begin
      opc   = (k < 2) ? `OPC_BEQ : `OPC_BNE;
      rt    = (k % 2 == 0) ? 5'd6 : 5'd7;
      equal = (regModel[5] == regModel[rt]);
      taken = (opc == `OPC_BEQ) ? equal : !equal;
      bits  = nextBits(16);
      pc    = nextBits(32);
      applyInputs(iTypeWord(opc, 5'd5, rt, bits[15:0]), pc, '0);
      bitCompare($sformatf("branch %h r5 r%0d pcSel", opc, rt), taken, pcSel);
      wordCompare("branch target", pc + (signExtend(bits[15:0]) << 2), branchPc);
    end
  endtask

  task automatic jumpTest;
    logic [31:0] bits;
    logic [31:0] pc;
    bits = nextBits(26);
    pc   = nextBits(32);
    applyInputs(iTypeWord(`OPC_J, bits[25:21], bits[20:16], bits[15:0]), pc, '0);
    bitCompare("j pcSel", 1'b1, pcSel);
    wordCompare("j target", {pc[31:28], bits[25:0], 2'b00}, branchPc);
    // Target straight from r5
    applyInputs(rTypeWord(5'd5, 5'd9, 5'd0, `FN_JR), nextBits(32), '0);
    bitCompare("jr pcSel", 1'b1, pcSel);
    wordCompare("jr target", regModel[5], branchPc);
  endtask

  task automatic hazardCase(input string testName, input decodePkg::instrWord instr,
                            input decodePkg::pipeHazardInfo hz, input logic expectStall,
                            input logic expectPcSel);
    applyInputs(instr, 32'h0000_1000, hz);
    stallCompare(testName, expectStall ? 3'b111 : 3'b000, stall);
    bitCompare({testName, " pcSel"}, expectPcSel, pcSel);
  endtask

  task automatic hazardTest;
    decodePkg::instrWord addWord;
    decodePkg::instrWord beqWord;
    addWord = rTypeWord(5'd3, 5'd4, 5'd8, `FN_ADD);
    // r5 equals r6 so beq is taken unless stalled
    beqWord = iTypeWord(`OPC_BEQ, 5'd5, 5'd6, 16'h0010);
    hazardCase("load-use rs", addWord,
               hazardFields(`OPC_LW, 5'd3, 5'd0, `OPC_RTYPE, 5'd0), 1'b1, 1'b0);
    hazardCase("load-use rt", addWord,
               hazardFields(`OPC_LB, 5'd4, 5'd0, `OPC_RTYPE, 5'd0), 1'b1, 1'b0);
    hazardCase("load-use other reg", addWord,
               hazardFields(`OPC_LH, 5'd9, 5'd0, `OPC_RTYPE, 5'd0), 1'b0, 1'b0);
    hazardCase("non-load in EX", addWord,
               hazardFields(`OPC_ADDI, 5'd3, 5'd0, `OPC_RTYPE, 5'd0), 1'b0, 1'b0);
    hazardCase("load-use zero reg", rTypeWord(5'd0, 5'd0, 5'd8, `FN_ADD),
               hazardFields(`OPC_LW, 5'd0, 5'd0, `OPC_RTYPE, 5'd0), 1'b0, 1'b0);
    // Branch operands still in flight
    hazardCase("branch vs EX rd", beqWord,
               hazardFields(`OPC_RTYPE, 5'd0, 5'd6, `OPC_RTYPE, 5'd0), 1'b1, 1'b0);
    hazardCase("branch vs EX addi", beqWord,
               hazardFields(`OPC_ADDI, 5'd5, 5'd0, `OPC_RTYPE, 5'd0), 1'b1, 1'b0);
    hazardCase("branch vs EX store", beqWord,
               hazardFields(`OPC_SW, 5'd5, 5'd5, `OPC_RTYPE, 5'd0), 1'b0, 1'b1);
    hazardCase("branch vs MEM load", beqWord,
               hazardFields(`OPC_SW, 5'd0, 5'd0, `OPC_LW, 5'd5), 1'b1, 1'b0);
    hazardCase("branch vs MEM store", beqWord,
               hazardFields(`OPC_SW, 5'd0, 5'd0, `OPC_SW, 5'd5), 1'b0, 1'b1);
    hazardCase("jr vs EX rd", rTypeWord(5'd5, 5'd0, 5'd0, `FN_JR),
               hazardFields(`OPC_RTYPE, 5'd0, 5'd5, `OPC_RTYPE, 5'd0), 1'b1, 1'b0);
  endtask

  task automatic rtGatingTest;
    decodePkg::pipeHazardInfo hz;
    // Nonzero r9 makes the gated read visible
    writeRegister(5'd9, nextBits(32) | 32'h1);
    hz = hazardFields(`OPC_LW, 5'd9, 5'd0, `OPC_RTYPE, 5'd0);
    hazardCase("addi rt ignored", iTypeWord(`OPC_ADDI, 5'd3, 5'd9, 16'h0004), hz, 1'b0, 1'b0);
    wordCompare("addi rt gated read", 32'd0, readData2);
    hazardCase("lw rt ignored", iTypeWord(`OPC_LW, 5'd3, 5'd9, 16'h0008), hz, 1'b0, 1'b0);
    hazardCase("sw rt used", iTypeWord(`OPC_SW, 5'd3, 5'd9, 16'h000c), hz, 1'b1, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic released;
    reset       = 1'b1;
    instruction = '0;
    pcPlusFour  = '0;
    writeAddr   = '0;
    writeData   = '0;
    regWrite    = 1'b0;
    hazardInfo  = '0;
    repeat (4) @(posedge Clock);
    reset <= 1'b0;
    waitResetRelease(released);

    if (!released) begin
      $display("Timeout: reset was never released");
      $display("test failed");
    end else begin
      registerFileTest();
      controlDecodeTest();
      immBranchTest();
      jumpTest();
      hazardTest();
      rtGatingTest();

      $display("errors: %0d", errorCount);
      if (errorCount == 0)
        $display("test passed");
      else
        $display("test failed");
    end
    $finish;
  end

endmodule

// ==== rtl/instructionDecode.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module instructionDecode (
  input  logic                      Clock,
  input  logic                      reset,
  input  decodePkg::instrWord       instruction,
  input  logic [`DECODE_XLEN-1:0]   pcPlusFour,
  input  logic [`DECODE_REG_AW-1:0] writeAddr,
  input  logic [`DECODE_XLEN-1:0]   writeData,
  input  logic                      regWrite,
  input  decodePkg::pipeHazardInfo  hazardInfo,
  output decodePkg::ctrlSignals     ctrl,
  output logic [`DECODE_XLEN-1:0]   readData1,
  output logic [`DECODE_XLEN-1:0]   readData2,
  output logic [`DECODE_XLEN-1:0]   imm32,
  output logic                      pcSel,
  output logic [`DECODE_XLEN-1:0]   branchPc,
  output decodePkg::stallSignals    stall
);

  decodePkg::useFlags        uses;
  logic [`DECODE_REG_AW-1:0] rtAddr;

  ////////////////////////////////////////////////////////////////////////////
  // Control decode and register read
  ////////////////////////////////////////////////////////////////////////////

  mainControl mainControl_i (
    .instruction (instruction),
    .ctrl        (ctrl),
    .uses        (uses)
  );

  // Port 2 reads r0 when rt is not a source
  assign rtAddr = uses.readsRt ? instruction.rFormat.rt : '0;

  registerFile registerFile_i (
    .Clock     (Clock),
    .reset     (reset),
    .readAddr1 (instruction.rFormat.rs),
    .readAddr2 (rtAddr),
    .writeAddr (writeAddr),
    .writeData (writeData),
    .regWrite  (regWrite),
    .readData1 (readData1),
    .readData2 (readData2)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Branch resolution and hazards
  ////////////////////////////////////////////////////////////////////////////

  branchResolve branchResolve_i (
    .instruction (instruction),
    .pcPlusFour  (pcPlusFour),
    .rsData      (readData1),
    .rtData      (readData2),
    .stallPc     (stall.stallPc),
    .imm32       (imm32),
    .pcSel       (pcSel),
    .branchPc    (branchPc)
  );

  hazardUnit hazardUnit_i (
    .instruction (instruction),
    .uses        (uses),
    .hazardInfo  (hazardInfo),
    .stall       (stall)
  );

endmodule

// ==== rtl/hazardUnit.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module hazardUnit (
  input  decodePkg::instrWord      instruction,
  input  decodePkg::useFlags       uses,
  input  decodePkg::pipeHazardInfo hazardInfo,
  output decodePkg::stallSignals   stall
);

  logic [`DECODE_REG_AW-1:0] rs;
  logic [`DECODE_REG_AW-1:0] rt;
  logic [`DECODE_REG_AW-1:0] exDest;
  logic                      exIsLoad;
  logic                      memIsLoad;
  logic                      loadUse;
  logic                      branchHazard;
  logic                      anyHazard;

  assign rs = instruction.iFormat.rs;
  assign rt = instruction.iFormat.rt;

  // Load classification for the later stages
  assign exIsLoad  = (hazardInfo.exOpcode == `OPC_LW) ||
                     (hazardInfo.exOpcode == `OPC_LH) ||
                     (hazardInfo.exOpcode == `OPC_LB);
  assign memIsLoad = (hazardInfo.memOpcode == `OPC_LW) ||
                     (hazardInfo.memOpcode == `OPC_LH) ||
                     (hazardInfo.memOpcode == `OPC_LB);

  // Register that EX will write or zero when none
  always_comb begin
    if (hazardInfo.exOpcode == `OPC_RTYPE)
      exDest = hazardInfo.exRd;
    else if ((hazardInfo.exOpcode == `OPC_ADDI) || exIsLoad)
      exDest = hazardInfo.exRt;
    else
      exDest = '0;
  end

  // Checks a destination against the sources this instruction reads
  function automatic logic sourceHit(input logic [`DECODE_REG_AW-1:0] dest);
    return (dest != '0) &&
           ((uses.readsRs && (dest == rs)) || (uses.readsRt && (dest == rt)));
  endfunction

  always_comb begin
    // Loaded value not ready for the next stage
    loadUse      = exIsLoad && sourceHit(hazardInfo.exRt);
    // Branch compares in ID need final register values
    branchHazard = uses.isBranch &&
                   (sourceHit(exDest) || (memIsLoad && sourceHit(hazardInfo.memDest)));
  end

  assign anyHazard = loadUse || branchHazard;

  // One hazard freezes PC, IF/ID and bubbles ID/EX
  assign stall.stallPc   = anyHazard;
  assign stall.stallId   = anyHazard;
  assign stall.stallIdEx = anyHazard;

endmodule

// ==== rtl/branchResolve.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module branchResolve (
  input  decodePkg::instrWord     instruction,
  input  logic [`DECODE_XLEN-1:0] pcPlusFour,
  input  logic [`DECODE_XLEN-1:0] rsData,
  input  logic [`DECODE_XLEN-1:0] rtData,
  input  logic                    stallPc,
  output logic [`DECODE_XLEN-1:0] imm32,
  output logic                    pcSel,
  output logic [`DECODE_XLEN-1:0] branchPc
);

  logic [`DECODE_XLEN-1:0] branchTarget;
  logic [`DECODE_XLEN-1:0] jumpTarget;
  logic [25:0]             jumpIndex;
  logic                    operandsEqual;
  logic                    taken;

  // Sign extension of the 16-bit immediate
  assign imm32 = {{(`DECODE_XLEN-16){instruction.iFormat.imm[15]}}, instruction.iFormat.imm};

  // Word offset relative to the delay slot address
  assign branchTarget = pcPlusFour + (imm32 << 2);

  // Jump index spans rs, rt and imm of the I view
  assign jumpIndex  = {instruction.iFormat.rs, instruction.iFormat.rt,
                       instruction.iFormat.imm};
  assign jumpTarget = {pcPlusFour[`DECODE_XLEN-1:28], jumpIndex, 2'b00};

  assign operandsEqual = (rsData == rtData);

  always_comb begin
    // Candidate stays visible even when not taken
    taken    = 1'b0;
    branchPc = branchTarget;

    case (instruction.iFormat.opcode)
      `OPC_BEQ: taken = operandsEqual;
      `OPC_BNE: taken = !operandsEqual;
      `OPC_J: begin
        taken    = 1'b1;
        branchPc = jumpTarget;
      end
      `OPC_RTYPE: begin
        // jr only, other functs fall through
        if (instruction.rFormat.funct == `FN_JR) begin
          taken    = 1'b1;
          branchPc = rsData;
        end
      end
      default: taken = 1'b0;
    endcase
  end

  // Redirect held off while fetch is stalled
  assign pcSel = taken && !stallPc;

endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module registerFile (
  input  logic                      Clock,
  input  logic                      reset,
  input  logic [`DECODE_REG_AW-1:0] readAddr1,
  input  logic [`DECODE_REG_AW-1:0] readAddr2,
  input  logic [`DECODE_REG_AW-1:0] writeAddr,
  input  logic [`DECODE_XLEN-1:0]   writeData,
  input  logic                      regWrite,
  output logic [`DECODE_XLEN-1:0]   readData1,
  output logic [`DECODE_XLEN-1:0]   readData2
);

  logic [`DECODE_XLEN-1:0] regs [`DECODE_REG_COUNT];
  logic                    writeValid;

  // r0 is never written
  assign writeValid = regWrite && (writeAddr != '0);

  always_ff @(posedge Clock) begin
    if (reset) begin
      for (int i = 0; i < `DECODE_REG_COUNT; i++)
        regs[i] <= '0;
    end else if (writeValid) begin
      regs[writeAddr] <= writeData;
    end
  end

  // Read port with r0 tie-off and same-cycle write bypass
  function automatic logic [`DECODE_XLEN-1:0] readPort(input logic [`DECODE_REG_AW-1:0] addr);
    if (addr == '0)
      return '0;
    else if (writeValid && (addr == writeAddr))
      return writeData;
    else
      return regs[addr];
  endfunction

  always_comb begin
    readData1 = readPort(readAddr1);
    readData2 = readPort(readAddr2);
  end

endmodule

// ==== rtl/mainControl.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module mainControl (
  input  decodePkg::instrWord   instruction,
  output decodePkg::ctrlSignals ctrl,
  output decodePkg::useFlags    uses
);

  // Size codes shared by loads and stores
  localparam logic [1:0] SizeByte = 2'd0;
  localparam logic [1:0] SizeHalf = 2'd1;
  localparam logic [1:0] SizeWord = 2'd2;

  always_comb begin
    // Unknown opcode or funct leaves everything low
    ctrl = '0;
    uses = '0;

    case (instruction.rFormat.opcode)
      `OPC_RTYPE: begin
        case (instruction.rFormat.funct)
          `FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT: begin
            // ALU ops write rd from rs and rt
            ctrl.regDst   = 1'b1;
            ctrl.regWrite = 1'b1;
            uses.readsRs  = 1'b1;
            uses.readsRt  = 1'b1;
          end
          `FN_JR: begin
            // Register jump resolved here, no writeback
            uses.readsRs  = 1'b1;
            uses.isBranch = 1'b1;
          end
          default: begin
            // sll r0 nop and unsupported functs
            ctrl = '0;
          end
        endcase
      end

      `OPC_ADDI: begin
        ctrl.aluSrc1  = 2'd1;
        ctrl.regWrite = 1'b1;
        uses.readsRs  = 1'b1;
      end

      // Loads
      `OPC_LB, `OPC_LH, `OPC_LW: begin
        ctrl.aluSrc1  = 2'd1;
        ctrl.rEnable  = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        uses.readsRs  = 1'b1;
        if (instruction.rFormat.opcode == `OPC_LB)
          ctrl.rWidth = SizeByte;
        else if (instruction.rFormat.opcode == `OPC_LH)
          ctrl.rWidth = SizeHalf;
        else
          ctrl.rWidth = SizeWord;
      end

      // Stores read rt as the data operand
      `OPC_SB, `OPC_SH, `OPC_SW: begin
        ctrl.aluSrc1 = 2'd1;
        ctrl.wEnable = 1'b1;
        uses.readsRs = 1'b1;
        uses.readsRt = 1'b1;
        if (instruction.rFormat.opcode == `OPC_SB)
          ctrl.wWidth = SizeByte;
        else if (instruction.rFormat.opcode == `OPC_SH)
          ctrl.wWidth = SizeHalf;
        else
          ctrl.wWidth = SizeWord;
      end

      // Conditional branches compare rs and rt
      `OPC_BEQ, `OPC_BNE: begin
        uses.readsRs  = 1'b1;
        uses.readsRt  = 1'b1;
        uses.isBranch = 1'b1;
      end

      // j needs no registers
      `OPC_J: begin
        ctrl = '0;
      end

      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

// ==== rtl/decodePkg.sv ====
`include "decode_params.svh"

package decodePkg;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction word views
  ////////////////////////////////////////////////////////////////////////////

  // Register format
  typedef struct packed {
    logic [5:0]                opcode;
    logic [`DECODE_REG_AW-1:0] rs;
    logic [`DECODE_REG_AW-1:0] rt;
    logic [`DECODE_REG_AW-1:0] rd;
    logic [4:0]                shamt;
    logic [5:0]                funct;
  } rFields;

  // Immediate format, also carries the jump index in rs/rt/imm
  typedef struct packed {
    logic [5:0]                opcode;
    logic [`DECODE_REG_AW-1:0] rs;
    logic [`DECODE_REG_AW-1:0] rt;
    logic [15:0]               imm;
  } iFields;

  // Same 32 bits, decoded either way
  typedef union packed {
    rFields rFormat;
    iFields iFormat;
  } instrWord;

  ////////////////////////////////////////////////////////////////////////////
  // Control, hazard and stall bundles
  ////////////////////////////////////////////////////////////////////////////

  // Downstream control, 12 bits
  typedef struct packed {
    logic       regDst;
    logic       aluSrc0;
    logic [1:0] aluSrc1;
    logic       rEnable;
    logic       wEnable;
    logic [1:0] rWidth;   // 0 byte, 1 half, 2 word
    logic [1:0] wWidth;
    logic       memToReg;
    logic       regWrite;
  } ctrlSignals;

  // Reported back by EX and MEM
  typedef struct packed {
    logic [5:0]                exOpcode;
    logic [`DECODE_REG_AW-1:0] exRt;
    logic [`DECODE_REG_AW-1:0] exRd;
    logic [5:0]                memOpcode;
    logic [`DECODE_REG_AW-1:0] memDest;
  } pipeHazardInfo;

  typedef struct packed {
    logic stallPc;
    logic stallId;
    logic stallIdEx;
  } stallSignals;

  // Which source registers the instruction really reads
  typedef struct packed {
    logic readsRs;
    logic readsRt;
    logic isBranch;
  } useFlags;

endpackage

// ==== rtl/decode_params.svh ====
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Datapath and register file geometry
`define DECODE_XLEN       32
`define DECODE_REG_AW     5
`define DECODE_REG_COUNT  32

// Primary opcodes, instruction bits 31..26
`define OPC_RTYPE 6'h00
`define OPC_J     6'h02
`define OPC_BEQ   6'h04
`define OPC_BNE   6'h05
`define OPC_ADDI  6'h08
`define OPC_LB    6'h20
`define OPC_LH    6'h21
`define OPC_LW    6'h23
`define OPC_SB    6'h28
`define OPC_SH    6'h29
`define OPC_SW    6'h2b

// R-type funct codes, instruction bits 5..0
`define FN_JR     6'h08
`define FN_ADD    6'h20
`define FN_SUB    6'h22
`define FN_AND    6'h24
`define FN_OR     6'h25
`define FN_SLT    6'h2a

`endif
